// File: hdl/csr_defs.svh
// Widths, CSR indices and constant register values of the machine-mode
// CSR file. Included by the package, every RTL block and the testbench
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Datapath widths
`define CSR_XLEN        32
`define CSR_PC_SIZE     24            // Stored exception PC
`define CSR_ADDR_SIZE   32            // Bad-address register
`define CSR_HART_ID_W   1
`define CSR_IDX_W       12

////////////////////////////////////////////////////////////
// CSR indices, machine mode only
////////////////////////////////////////////////////////////
`define CSR_ADDR_MSTATUS      12'h300
`define CSR_ADDR_MISA         12'h301
`define CSR_ADDR_MIE          12'h304
`define CSR_ADDR_MTVEC        12'h305
`define CSR_ADDR_MEPC         12'h341
`define CSR_ADDR_MCAUSE       12'h342
`define CSR_ADDR_MBADADDR     12'h343
`define CSR_ADDR_MIP          12'h344
`define CSR_ADDR_MCYCLE       12'hB00
`define CSR_ADDR_MINSTRET     12'hB02
`define CSR_ADDR_MCYCLEH      12'hB80
`define CSR_ADDR_MINSTRETH    12'hB82
`define CSR_ADDR_COUNTERSTOP  12'hBFF  // Custom, outside the ISA map
`define CSR_ADDR_MVENDORID    12'hF11
`define CSR_ADDR_MARCHID      12'hF12
`define CSR_ADDR_MIMPID       12'hF13
`define CSR_ADDR_MHARTID      12'hF14

// Identity values
`define CSR_MVENDORID_VAL  32'h0000_0536
`define CSR_MARCHID_VAL    32'h0000_E203
`define CSR_MIMPID_VAL     32'h0000_0001
`define CSR_MISA_VAL       32'h4000_1104  // RV32 with I, M and C
`define CSR_MTVEC_BASE     32'h8000_0000  // Fixed trap vector

// Bit positions in mstatus, mie and mip
`define CSR_MIE_BIT   3
`define CSR_MPIE_BIT  7
`define CSR_MEI_BIT   11
`define CSR_MTI_BIT   7
`define CSR_MSI_BIT   3

`endif

// File: hdl/csr_pkg.sv
// Shared types of the CSR file: data words, the write bundle and the
// commit events. Blocks refer to them as csr_pkg::name
`include "csr_defs.svh"

package csr_pkg;

  typedef logic [`CSR_XLEN-1:0]  csr_word_t;   // One CSR data word
  typedef logic [`CSR_IDX_W-1:0] csr_idx_t;    // CSR index

  // Machine interrupt triple, enables or pending bits
  typedef struct packed {
    logic meie;
    logic mtie;
    logic msie;
  } irq_bits_t;

  // mstatus field layout, MSB first
  typedef struct packed {
    logic       sd;          // 31
    logic [7:0] rsv_30_23;
    logic [5:0] tsr_mprv;    // 22:17
    logic [1:0] xs;          // 16:15
    logic [1:0] fs;          // 14:13
    logic [1:0] mpp;         // 12:11
    logic [1:0] rsv_10_9;
    logic       spp;
    logic       mpie;        // 7
    logic       rsv_6;
    logic       spie;
    logic       upie;
    logic       mie;         // 3
    logic       rsv_2;
    logic       sie;
    logic       uie;
  } status_view_t;

  // Shared bit layout of mie and mip
  typedef struct packed {
    logic [19:0] rsv_31_12;
    logic        mei;        // 11
    logic [2:0]  rsv_10_8;
    logic        mti;        // 7
    logic [2:0]  rsv_6_4;
    logic        msi;        // 3
    logic [2:0]  rsv_2_0;
  } irq_view_t;

  // Write data word, seen raw or through one of the two field views
  typedef union packed {
    csr_word_t    raw;
    status_view_t status_view;
    irq_view_t    irq_view;
  } csr_word_u;

  // Qualified CSR write
  typedef struct packed {
    logic      wen;          // csr_ena and csr_wr_en
    csr_idx_t  idx;
    csr_word_u data;
  } csr_wr_t;

  // Single-cycle commit events from the pipeline
  typedef struct packed {
    logic                      trap;         // Trap entry, stacks MIE
    logic                      mret;
    logic                      epc_ena;
    logic [`CSR_PC_SIZE-1:0]   epc;
    logic                      cause_ena;
    csr_word_t                 cause;
    logic                      badaddr_ena;
    logic [`CSR_ADDR_SIZE-1:0] badaddr;
    logic                      instret;      // One retired instruction
  } cmt_t;

endpackage

// File: hdl/csr_mstatus_fsm.sv
// mstatus interrupt-enable stack. Tracks the MIE/MPIE pair as a four-state
// machine stepped by trap entry, MRET and CSR writes, in that priority,
// and builds the mstatus read word with MPP fixed at machine mode
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_mstatus_fsm (
  input  logic               clk,
  input  logic               arst_n,
  input  csr_pkg::csr_wr_t   wr,
  input  csr_pkg::cmt_t      cmt,
  output logic               status_mie_r,
  output csr_pkg::csr_word_t mstatus_word
);

  // State is {MPIE, MIE}
  localparam logic [1:0] ST_OFF  = 2'b00;   // Interrupts off, nothing stacked
  localparam logic [1:0] ST_ON   = 2'b01;   // Enabled
  localparam logic [1:0] ST_TRAP = 2'b10;   // In handler, enable stacked
  localparam logic [1:0] ST_BOTH = 2'b11;

  logic [1:0] state_r;
  logic [1:0] state_nxt;
  logic       wr_mstatus;

  assign wr_mstatus = wr.wen & (wr.idx == `CSR_ADDR_MSTATUS);

  always_comb begin
    state_nxt = state_r;                       // Hold by default
    if (cmt.trap) begin
      // MIE moves into MPIE and is cleared
      case (state_r)
        ST_ON, ST_BOTH: state_nxt = ST_TRAP;
        default:        state_nxt = ST_OFF;
      endcase
    end else if (cmt.mret) begin
      // MPIE restores MIE and is set again
      case (state_r)
        ST_TRAP, ST_BOTH: state_nxt = ST_BOTH;
        default:          state_nxt = ST_TRAP;
      endcase
    end else if (wr_mstatus) begin
      state_nxt = {wr.data.status_view.mpie, wr.data.status_view.mie};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_r <= ST_OFF;
    end else begin
      state_r <= state_nxt;
    end
  end

  assign status_mie_r = state_r[0];

  ////////////////////////////////////////////////////////////
  // Read word
  ////////////////////////////////////////////////////////////
  always_comb begin
    mstatus_word                = '0;          // SD, FS and XS stay zero
    mstatus_word[12:11]         = 2'b11;       // MPP, M mode only
    mstatus_word[`CSR_MPIE_BIT] = state_r[1];
    mstatus_word[`CSR_MIE_BIT]  = state_r[0];
  end

endmodule

// File: hdl/csr_counters.sv
// Performance counters of the CSR file. mcycle and minstret are 64 bits,
// each kept as a low and a high word that the CSR port can overwrite.
// counterstop holds the stop bits for cycle, time and instret counting
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_counters (
  input  logic               clk,
  input  logic               clk_aon,
  input  logic               arst_n,
  input  csr_pkg::csr_wr_t   wr,
  input  logic               instret,
  output logic               tm_stop,
  output csr_pkg::csr_word_t mcycle_word,
  output csr_pkg::csr_word_t mcycleh_word,
  output csr_pkg::csr_word_t minstret_word,
  output csr_pkg::csr_word_t minstreth_word,
  output csr_pkg::csr_word_t counterstop_word
);

  csr_pkg::csr_word_t mcycle_r;
  csr_pkg::csr_word_t mcycleh_r;
  csr_pkg::csr_word_t minstret_r;
  csr_pkg::csr_word_t minstreth_r;
  logic [2:0]         counterstop_r;   // Only three bits implemented

  logic wr_mcycle;
  logic wr_mcycleh;
  logic wr_minstret;
  logic wr_minstreth;
  logic wr_counterstop;
  logic cy_stop;
  logic ir_stop;

  // Write strobes for this block's own indices
  assign wr_mcycle      = wr.wen & (wr.idx == `CSR_ADDR_MCYCLE);
  assign wr_mcycleh     = wr.wen & (wr.idx == `CSR_ADDR_MCYCLEH);
  assign wr_minstret    = wr.wen & (wr.idx == `CSR_ADDR_MINSTRET);
  assign wr_minstreth   = wr.wen & (wr.idx == `CSR_ADDR_MINSTRETH);
  assign wr_counterstop = wr.wen & (wr.idx == `CSR_ADDR_COUNTERSTOP);

  assign cy_stop = counterstop_r[0];   // Freeze mcycle
  assign tm_stop = counterstop_r[1];   // Time stop, output only
  assign ir_stop = counterstop_r[2];   // Freeze minstret

  ////////////////////////////////////////////////////////////
  // Cycle counter, always-on clock
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_aon or negedge arst_n) begin
    if (!arst_n) begin
      mcycle_r  <= '0;
      mcycleh_r <= '0;
    end else begin
      if (wr_mcycle) begin
        mcycle_r <= wr.data.raw;              // Write replaces the increment
      end else if (!cy_stop) begin
        mcycle_r <= mcycle_r + 1'b1;
      end
      if (wr_mcycleh) begin
        mcycleh_r <= wr.data.raw;
      end else if (!cy_stop && (mcycle_r == '1)) begin
        mcycleh_r <= mcycleh_r + 1'b1;        // Carry on low-word wrap
      end
    end
  end

  // Retired-instruction counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      minstret_r  <= '0;
      minstreth_r <= '0;
    end else begin
      if (wr_minstret) begin
        minstret_r <= wr.data.raw;
      end else if (!ir_stop && instret) begin
        minstret_r <= minstret_r + 1'b1;
      end
      if (wr_minstreth) begin
        minstreth_r <= wr.data.raw;
      end else if (!ir_stop && instret && (minstret_r == '1)) begin
        minstreth_r <= minstreth_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      counterstop_r <= '0;
    end else if (wr_counterstop) begin
      counterstop_r <= wr.data.raw[2:0];
    end
  end

  assign mcycle_word      = mcycle_r;
  assign mcycleh_word     = mcycleh_r;
  assign minstret_word    = minstret_r;
  assign minstreth_word   = minstreth_r;
  assign counterstop_word = csr_pkg::csr_word_t'(counterstop_r);   // Upper bits zero

endmodule

// File: hdl/csr_trap_regs.sv
// Trap registers mepc, mcause and mbadaddr. A commit event loads a
// register ahead of a CSR write to the same register in that cycle
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_trap_regs (
  input  logic               clk,
  input  logic               arst_n,
  input  csr_pkg::csr_wr_t   wr,
  input  csr_pkg::cmt_t      cmt,
  output csr_pkg::csr_word_t mepc_word,
  output csr_pkg::csr_word_t mcause_word,
  output csr_pkg::csr_word_t mbadaddr_word
);

  logic [`CSR_PC_SIZE-1:1]   epc_r;          // Bit 0 is always zero
  logic                      cause_irq_r;    // mcause bit 31
  logic [3:0]                cause_code_r;   // Exception code
  logic [`CSR_ADDR_SIZE-1:0] badaddr_r;

  logic wr_mepc;
  logic wr_mcause;
  logic wr_mbadaddr;

  assign wr_mepc     = wr.wen & (wr.idx == `CSR_ADDR_MEPC);
  assign wr_mcause   = wr.wen & (wr.idx == `CSR_ADDR_MCAUSE);
  assign wr_mbadaddr = wr.wen & (wr.idx == `CSR_ADDR_MBADADDR);

  // mepc keeps an aligned PC so a return never misaligns
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      epc_r <= '0;
    end else if (cmt.epc_ena) begin
      epc_r <= cmt.epc[`CSR_PC_SIZE-1:1];
    end else if (wr_mepc) begin
      epc_r <= wr.data.raw[`CSR_PC_SIZE-1:1];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cause_irq_r  <= 1'b0;
      cause_code_r <= '0;
    end else if (cmt.cause_ena) begin
      cause_irq_r  <= cmt.cause[`CSR_XLEN-1];
      cause_code_r <= cmt.cause[3:0];
    end else if (wr_mcause) begin
      cause_irq_r  <= wr.data.raw[`CSR_XLEN-1];
      cause_code_r <= wr.data.raw[3:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      badaddr_r <= '0;
    end else if (cmt.badaddr_ena) begin
      badaddr_r <= cmt.badaddr;
    end else if (wr_mbadaddr) begin
      badaddr_r <= wr.data.raw[`CSR_ADDR_SIZE-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Read words, zero-extended
  ////////////////////////////////////////////////////////////
  assign mepc_word     = csr_pkg::csr_word_t'({epc_r, 1'b0});
  assign mcause_word   = {cause_irq_r, {(`CSR_XLEN-5){1'b0}}, cause_code_r};   // 30:4 zero
  assign mbadaddr_word = csr_pkg::csr_word_t'(badaddr_r);

endmodule

// File: hdl/csr_irq_regs.sv
// Machine interrupt registers. mie holds the three enables, written
// through the interrupt view of the write word, and mip samples the
// external, software and timer lines one clk after they change
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_irq_regs (
  input  logic               clk,
  input  logic               arst_n,
  input  csr_pkg::csr_wr_t   wr,
  input  logic               ext_irq_r,
  input  logic               sft_irq_r,
  input  logic               tmr_irq_r,
  output csr_pkg::irq_bits_t irq_en,
  output csr_pkg::csr_word_t mie_word,
  output csr_pkg::csr_word_t mip_word
);

  csr_pkg::irq_bits_t mie_r;   // Enables
  csr_pkg::irq_bits_t mip_r;   // Sampled lines, read only
  logic               wr_mie;

  assign wr_mie = wr.wen & (wr.idx == `CSR_ADDR_MIE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mie_r <= '0;
    end else if (wr_mie) begin
      mie_r.meie <= wr.data.irq_view.mei;
      mie_r.mtie <= wr.data.irq_view.mti;
      mie_r.msie <= wr.data.irq_view.msi;
    end
  end

  // Pending bits follow the lines every cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mip_r <= '0;
    end else begin
      mip_r.meie <= ext_irq_r;
      mip_r.mtie <= tmr_irq_r;
      mip_r.msie <= sft_irq_r;
    end
  end

  assign irq_en = mie_r;

  always_comb begin
    mie_word               = '0;
    mie_word[`CSR_MEI_BIT] = mie_r.meie;
    mie_word[`CSR_MTI_BIT] = mie_r.mtie;
    mie_word[`CSR_MSI_BIT] = mie_r.msie;
    mip_word               = '0;
    mip_word[`CSR_MEI_BIT] = mip_r.meie;
    mip_word[`CSR_MTI_BIT] = mip_r.mtie;
    mip_word[`CSR_MSI_BIT] = mip_r.msie;
  end

endmodule

// File: hdl/csr_file_top.sv
// Machine-mode CSR file. Qualifies CSR writes into one bundle for the
// register blocks, fans out the commit events and returns read data
// through a combinational OR mux that gives zero for unknown indices
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_file_top (
  input  logic                       clk,
  input  logic                       clk_aon,
  input  logic                       arst_n,
  input  logic                       csr_ena,
  input  logic                       csr_wr_en,
  input  logic                       csr_rd_en,
  input  csr_pkg::csr_idx_t          csr_idx,
  input  csr_pkg::csr_word_t         wbck_csr_dat,
  input  csr_pkg::cmt_t              cmt,
  input  logic                       ext_irq_r,
  input  logic                       sft_irq_r,
  input  logic                       tmr_irq_r,
  input  logic [`CSR_HART_ID_W-1:0]  core_mhartid,
  output csr_pkg::csr_word_t         read_csr_dat,
  output logic                       status_mie_r,
  output logic                       tm_stop,
  output csr_pkg::irq_bits_t         irq_en
);

  csr_pkg::csr_wr_t   wr;
  logic               rd_ena;
  csr_pkg::csr_word_t mstatus_word;
  csr_pkg::csr_word_t mie_word;
  csr_pkg::csr_word_t mip_word;
  csr_pkg::csr_word_t mepc_word;
  csr_pkg::csr_word_t mcause_word;
  csr_pkg::csr_word_t mbadaddr_word;
  csr_pkg::csr_word_t mcycle_word;
  csr_pkg::csr_word_t mcycleh_word;
  csr_pkg::csr_word_t minstret_word;
  csr_pkg::csr_word_t minstreth_word;
  csr_pkg::csr_word_t counterstop_word;
  csr_pkg::csr_word_t mhartid_word;

  // Selected word or zero
  function automatic csr_pkg::csr_word_t pick(input csr_pkg::csr_idx_t  idx,
                                              input csr_pkg::csr_idx_t  addr,
                                              input csr_pkg::csr_word_t word);
    pick = (idx == addr) ? word : '0;
  endfunction

  assign wr.wen      = csr_ena & csr_wr_en;
  assign wr.idx      = csr_idx;
  assign wr.data.raw = wbck_csr_dat;
  assign rd_ena      = csr_ena & csr_rd_en;

  assign mhartid_word = csr_pkg::csr_word_t'(core_mhartid);

  ////////////////////////////////////////////////////////////
  // Register blocks
  ////////////////////////////////////////////////////////////
  csr_mstatus_fsm u_mstatus (
    .clk, .arst_n, .wr, .cmt,
    .status_mie_r, .mstatus_word
  );

  csr_counters u_counters (
    .clk, .clk_aon, .arst_n, .wr,
    .instret (cmt.instret),
    .tm_stop, .mcycle_word, .mcycleh_word,
    .minstret_word, .minstreth_word, .counterstop_word
  );

  csr_trap_regs u_trap_regs (
    .clk, .arst_n, .wr, .cmt,
    .mepc_word, .mcause_word, .mbadaddr_word
  );

  csr_irq_regs u_irq_regs (
    .clk, .arst_n, .wr,
    .ext_irq_r, .sft_irq_r, .tmr_irq_r,
    .irq_en, .mie_word, .mip_word
  );

  // Read mux, zero when no read is strobed
  always_comb begin
    read_csr_dat = '0;
    if (rd_ena) begin
      read_csr_dat = pick(csr_idx, `CSR_ADDR_MSTATUS,     mstatus_word)
                   | pick(csr_idx, `CSR_ADDR_MISA,        `CSR_MISA_VAL)
                   | pick(csr_idx, `CSR_ADDR_MIE,         mie_word)
                   | pick(csr_idx, `CSR_ADDR_MTVEC,       `CSR_MTVEC_BASE)
                   | pick(csr_idx, `CSR_ADDR_MEPC,        mepc_word)
                   | pick(csr_idx, `CSR_ADDR_MCAUSE,      mcause_word)
                   | pick(csr_idx, `CSR_ADDR_MBADADDR,    mbadaddr_word)
                   | pick(csr_idx, `CSR_ADDR_MIP,         mip_word)
                   | pick(csr_idx, `CSR_ADDR_MCYCLE,      mcycle_word)
                   | pick(csr_idx, `CSR_ADDR_MCYCLEH,     mcycleh_word)
                   | pick(csr_idx, `CSR_ADDR_MINSTRET,    minstret_word)
                   | pick(csr_idx, `CSR_ADDR_MINSTRETH,   minstreth_word)
                   | pick(csr_idx, `CSR_ADDR_COUNTERSTOP, counterstop_word)
                   | pick(csr_idx, `CSR_ADDR_MVENDORID,   `CSR_MVENDORID_VAL)
                   | pick(csr_idx, `CSR_ADDR_MARCHID,     `CSR_MARCHID_VAL)
                   | pick(csr_idx, `CSR_ADDR_MIMPID,      `CSR_MIMPID_VAL)
                   | pick(csr_idx, `CSR_ADDR_MHARTID,     mhartid_word);
    end
  end

endmodule

// File: testbench/tb_csr_file.sv
// Testbench for the machine-mode CSR file. Drives CSR reads, writes and
// commit pulses into csr_file_top and checks read data and outputs
// against values built from the register rules. One line per test
`timescale 1ns/10ps
`include "csr_defs.svh"

module tb_csr_file;

  localparam int MAX_CYCLES = 2000;   // Tests need about 600

  logic                      clk;
  logic                      clk_aon;
  logic                      arst_n;
  logic                      csr_ena;
  logic                      csr_wr_en;
  logic                      csr_rd_en;
  csr_pkg::csr_idx_t         csr_idx;
  csr_pkg::csr_word_t        wbck_csr_dat;
  csr_pkg::cmt_t             cmt;
  logic                      ext_irq_r;
  logic                      sft_irq_r;
  logic                      tmr_irq_r;
  logic [`CSR_HART_ID_W-1:0] core_mhartid;
  csr_pkg::csr_word_t        read_csr_dat;
  logic                      status_mie_r;
  logic                      tm_stop;
  csr_pkg::irq_bits_t        irq_en;

  int          errors    = 0;
  int          test_base = 0;   // Error count when the test started
  int          n_pass    = 0;
  int          n_fail    = 0;
  int unsigned cyc       = 0;   // Rising edges since time zero
  int unsigned read_cyc;        // Edge count at the last read sample

  assign clk_aon = clk;         // Counters see the same clock

  csr_file_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;      // 8 ns period
  end

  // Cycle limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cyc);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Concurrent checks
  ////////////////////////////////////////////////////////////
  idle_read_zero: assert property (@(posedge clk) disable iff (!arst_n)
      !(csr_ena && csr_rd_en) |-> (read_csr_dat == '0))
    else begin
      $display("** Error at %0t ns: read data not zero without a read strobe", $time);
      errors++;
    end

  // Trap entry always clears MIE
  trap_clears_mie: assert property (@(posedge clk) disable iff (!arst_n)
      cmt.trap |=> !status_mie_r)
    else begin
      $display("** Error at %0t ns: MIE still set after trap entry", $time);
      errors++;
    end

  ////////////////////////////////////////////////////////////
  // Stimulus and check tasks
  ////////////////////////////////////////////////////////////
  task automatic tick();
    @(posedge clk);
    #1;                         // Drive point after the edge
  endtask

  task automatic check_word(input string what, input csr_pkg::csr_word_t got,
                            input csr_pkg::csr_word_t exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic csr_read(input csr_pkg::csr_idx_t idx, output csr_pkg::csr_word_t data);
    csr_ena   = 1'b1;
    csr_rd_en = 1'b1;
    csr_idx   = idx;
    @(negedge clk);             // Sample mid-cycle once the read mux has settled
    data      = read_csr_dat;
    read_cyc  = cyc;
    tick();
    csr_ena   = 1'b0;
    csr_rd_en = 1'b0;
  endtask

  task automatic read_expect(input string what, input csr_pkg::csr_idx_t idx,
                             input csr_pkg::csr_word_t exp);
    csr_pkg::csr_word_t got;
    csr_read(idx, got);
    check_word(what, got, exp);
  endtask

  task automatic csr_write(input csr_pkg::csr_idx_t idx, input csr_pkg::csr_word_t data);
    csr_ena      = 1'b1;
    csr_wr_en    = 1'b1;
    csr_idx      = idx;
    wbck_csr_dat = data;
    tick();                     // Lands on this edge
    csr_ena      = 1'b0;
    csr_wr_en    = 1'b0;
  endtask

  task automatic commit_pulse(input csr_pkg::cmt_t ev);
    cmt = ev;
    tick();
    cmt = '0;                   // Single-cycle pulse
  endtask

  // Commit event and CSR write in the same cycle
  task automatic commit_and_write(input csr_pkg::cmt_t ev, input csr_pkg::csr_idx_t idx,
                                  input csr_pkg::csr_word_t data);
    cmt          = ev;
    csr_ena      = 1'b1;
    csr_wr_en    = 1'b1;
    csr_idx      = idx;
    wbck_csr_dat = data;
    tick();
    cmt          = '0;
    csr_ena      = 1'b0;
    csr_wr_en    = 1'b0;
  endtask

  task automatic start_test();
    test_base = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_base) begin
      n_pass++;
      $display("[%0t ns] %s: pass", $time, name);
    end else begin
      n_fail++;
      $display("[%0t ns] %s: FAIL with %0d errors", $time, name, errors - test_base);
    end
  endtask

  // mstatus with MPP = 11 and the given MPIE/MIE pair
  function automatic csr_pkg::csr_word_t mstatus_val(input logic mpie, input logic mie);
    mstatus_val    = 32'h0000_1800;
    mstatus_val[7] = mpie;
    mstatus_val[3] = mie;
  endfunction

  // mie/mip layout with external at 11, timer at 7 and software at 3
  function automatic csr_pkg::csr_word_t irq_word(input logic ei, input logic ti,
                                                  input logic si);
    irq_word     = '0;
    irq_word[11] = ei;
    irq_word[7]  = ti;
    irq_word[3]  = si;
  endfunction

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    csr_pkg::csr_word_t d;
    csr_pkg::csr_word_t r1;
    csr_pkg::csr_word_t r2;
    csr_pkg::cmt_t      ev;
    int unsigned        c1;
    int                 k;

    void'($urandom(67534));
    arst_n       = 1'b0;
    csr_ena      = 1'b0;
    csr_wr_en    = 1'b0;
    csr_rd_en    = 1'b0;
    csr_idx      = '0;
    wbck_csr_dat = '0;
    cmt          = '0;
    ext_irq_r    = 1'b0;
    sft_irq_r    = 1'b0;
    tmr_irq_r    = 1'b0;
    core_mhartid = '1;
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Reset values and identity words
    start_test();
    check_word("status_mie_r", 32'(status_mie_r), '0);
    check_word("irq_en", 32'(irq_en), '0);
    check_word("tm_stop", 32'(tm_stop), '0);
    read_expect("mstatus", `CSR_ADDR_MSTATUS, 32'h0000_1800);
    read_expect("mie", `CSR_ADDR_MIE, '0);
    read_expect("mip", `CSR_ADDR_MIP, '0);
    read_expect("mcause", `CSR_ADDR_MCAUSE, '0);
    read_expect("counterstop", `CSR_ADDR_COUNTERSTOP, '0);
    read_expect("misa", `CSR_ADDR_MISA, `CSR_MISA_VAL);
    read_expect("mvendorid", `CSR_ADDR_MVENDORID, `CSR_MVENDORID_VAL);
    read_expect("marchid", `CSR_ADDR_MARCHID, `CSR_MARCHID_VAL);
    read_expect("mimpid", `CSR_ADDR_MIMPID, `CSR_MIMPID_VAL);
    read_expect("mtvec", `CSR_ADDR_MTVEC, `CSR_MTVEC_BASE);
    read_expect("mhartid", `CSR_ADDR_MHARTID, 32'(core_mhartid));
    read_expect("unknown index", 12'h7C0, '0);
    end_test("reset values");

    // MIE/MPIE stack
    start_test();
    csr_write(`CSR_ADDR_MSTATUS, mstatus_val(1'b0, 1'b1));
    check_word("status_mie_r after write", 32'(status_mie_r), 32'd1);
    read_expect("mstatus after write", `CSR_ADDR_MSTATUS, mstatus_val(1'b0, 1'b1));
    ev      = '0;
    ev.trap = 1'b1;
    commit_pulse(ev);
    check_word("status_mie_r after trap", 32'(status_mie_r), '0);
    read_expect("mstatus after trap", `CSR_ADDR_MSTATUS, mstatus_val(1'b1, 1'b0));
    ev      = '0;
    ev.mret = 1'b1;
    commit_pulse(ev);
    check_word("status_mie_r after mret", 32'(status_mie_r), 32'd1);
    read_expect("mstatus after mret", `CSR_ADDR_MSTATUS, mstatus_val(1'b1, 1'b1));
    ev.trap = 1'b1;                             // Trap and MRET together
    commit_pulse(ev);
    read_expect("mstatus after trap with mret", `CSR_ADDR_MSTATUS, mstatus_val(1'b1, 1'b0));
    end_test("mstatus stack");

    // mie masking and mip sampling
    start_test();
    d = $urandom;
    csr_write(`CSR_ADDR_MIE, d);
    read_expect("mie", `CSR_ADDR_MIE, irq_word(d[11], d[7], d[3]));
    check_word("irq_en", 32'(irq_en), 32'({d[11], d[7], d[3]}));
    r1 = '0;                                    // Lines low so far
    for (k = 0; k < 4; k++) begin
      d         = $urandom;
      ext_irq_r = d[0];
      sft_irq_r = d[1];
      tmr_irq_r = d[2];
      read_expect("mip before sample", `CSR_ADDR_MIP, r1);   // One-cycle lag
      r1 = irq_word(d[0], d[2], d[1]);
      read_expect("mip after sample", `CSR_ADDR_MIP, r1);
    end
    ext_irq_r = 1'b0;
    sft_irq_r = 1'b0;
    tmr_irq_r = 1'b0;
    end_test("interrupt registers");

    // Trap registers
    start_test();
    d          = $urandom;
    ev         = '0;
    ev.epc_ena = 1'b1;
    ev.epc     = d[`CSR_PC_SIZE-1:0];
    commit_pulse(ev);
    read_expect("mepc", `CSR_ADDR_MEPC, d & 32'h00FF_FFFE);
    d            = $urandom;
    ev           = '0;
    ev.cause_ena = 1'b1;
    ev.cause     = d;
    commit_pulse(ev);
    read_expect("mcause", `CSR_ADDR_MCAUSE, d & 32'h8000_000F);
    d              = $urandom;
    ev             = '0;
    ev.badaddr_ena = 1'b1;
    ev.badaddr     = d;
    commit_pulse(ev);
    read_expect("mbadaddr", `CSR_ADDR_MBADADDR, d);
    // Commit beats a CSR write to the same register
    d          = $urandom;
    r2         = ~d;                            // Write data differs in every bit
    ev         = '0;
    ev.epc_ena = 1'b1;
    ev.epc     = d[`CSR_PC_SIZE-1:0];
    commit_and_write(ev, `CSR_ADDR_MEPC, r2);
    read_expect("mepc commit over write", `CSR_ADDR_MEPC, d & 32'h00FF_FFFE);
    ev           = '0;
    ev.cause_ena = 1'b1;
    ev.cause     = d;
    commit_and_write(ev, `CSR_ADDR_MCAUSE, r2);
    read_expect("mcause commit over write", `CSR_ADDR_MCAUSE, d & 32'h8000_000F);
    ev             = '0;
    ev.badaddr_ena = 1'b1;
    ev.badaddr     = d;
    commit_and_write(ev, `CSR_ADDR_MBADADDR, r2);
    read_expect("mbadaddr commit over write", `CSR_ADDR_MBADADDR, d);
    end_test("trap registers");

    // Counting and carry
    start_test();
    k = 5 + ($urandom % 20);
    csr_read(`CSR_ADDR_MCYCLE, r1);
    c1 = read_cyc;
    repeat (k) tick();
    csr_read(`CSR_ADDR_MCYCLE, r2);
    check_word("mcycle delta", r2 - r1, read_cyc - c1);
    csr_read(`CSR_ADDR_MCYCLEH, r1);
    csr_write(`CSR_ADDR_MCYCLE, 32'hFFFF_FFFE);
    repeat (3) tick();                          // Wrap lands in here
    read_expect("mcycleh after wrap", `CSR_ADDR_MCYCLEH, r1 + 1);
    repeat (4) tick();
    read_expect("mcycleh single carry", `CSR_ADDR_MCYCLEH, r1 + 1);
    csr_read(`CSR_ADDR_MINSTRET, r1);
    k          = 1 + ($urandom % 8);
    ev         = '0;
    ev.instret = 1'b1;
    repeat (k) commit_pulse(ev);
    read_expect("minstret", `CSR_ADDR_MINSTRET, r1 + k);
    end_test("counters");

    // Stop bits
    start_test();
    csr_write(`CSR_ADDR_COUNTERSTOP, 32'd5);
    read_expect("counterstop", `CSR_ADDR_COUNTERSTOP, 32'd5);
    csr_read(`CSR_ADDR_MCYCLE, r1);
    repeat (6) tick();
    read_expect("mcycle stopped", `CSR_ADDR_MCYCLE, r1);
    csr_read(`CSR_ADDR_MINSTRET, r1);
    repeat (3) commit_pulse(ev);                // Still instret pulses
    read_expect("minstret stopped", `CSR_ADDR_MINSTRET, r1);
    check_word("tm_stop with 5", 32'(tm_stop), '0);
    csr_write(`CSR_ADDR_COUNTERSTOP, 32'd2);
    check_word("tm_stop with 2", 32'(tm_stop), 32'd1);
    csr_write(`CSR_ADDR_COUNTERSTOP, 32'd0);
    check_word("tm_stop cleared", 32'(tm_stop), '0);
    end_test("counterstop");

    $display("Tests passed: %0d, failed: %0d, errors: %0d", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_mstatus_fsm.sv
hdl/csr_counters.sv
hdl/csr_trap_regs.sv
hdl/csr_irq_regs.sv
hdl/csr_file_top.sv
testbench/tb_csr_file.sv

// File: Bender.yml
package:
  name: csr_file

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/csr_pkg.sv
      - hdl/csr_mstatus_fsm.sv
      - hdl/csr_counters.sv
      - hdl/csr_trap_regs.sv
      - hdl/csr_irq_regs.sv
      - hdl/csr_file_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_csr_file.sv
